// File: source/RvPkg.sv
package RvPkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int DataWidth    = 32;
    localparam int PcWidth      = 32;
    localparam int RegAddrWidth = 5;
    localparam int RegCount     = 32;

    // Memory depths in words
    localparam int InstMemWords   = 256;
    localparam int DataMemWords   = 256;
    localparam int InstIndexWidth = $clog2(InstMemWords);
    localparam int DataIndexWidth = $clog2(DataMemWords);

    // Memory-mapped I/O, byte addresses
    localparam logic [DataWidth-1:0] LedAddr    = 32'h0000_0200;
    localparam logic [DataWidth-1:0] SwitchAddr = 32'h0000_0204;

    // ------------------------------
    // Encodings
    // ------------------------------
    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OpReg    = 7'b0110011,
        OpImm    = 7'b0010011,
        OpLui    = 7'b0110111,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111
    } OpcodeE;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluPassB
    } AluOpE;

    // ------------------------------
    // Stage registers and buses
    // ------------------------------
    typedef struct packed {
        logic                 valid;
        logic [PcWidth-1:0]   pc;
        logic [31:0]          instr;
    } FetchToDecodeT;

    typedef struct packed {
        logic                    valid;
        logic [PcWidth-1:0]      pc;
        AluOpE                   aluOp;
        logic [DataWidth-1:0]    operandA;
        logic [DataWidth-1:0]    operandB;
        logic [DataWidth-1:0]    storeData;
        logic [RegAddrWidth-1:0] rd;
        logic                    regWrite;
        logic                    isLoad;
        logic                    isStore;
        logic                    isBranch;
        logic                    isJump;
        logic                    branchNotEqual;
        logic [PcWidth-1:0]      branchOffset;
    } DecodeToExecT;

    typedef struct packed {
        logic [DataWidth-1:0] addr;
        logic [DataWidth-1:0] wrData;
        logic                 wrEn;
        logic                 rdEn;
    } DataBusT;

    typedef struct packed {
        logic                    en;
        logic [RegAddrWidth-1:0] rd;
        logic [DataWidth-1:0]    data;
    } WritebackT;

endpackage

// File: source/InstMemory.sv
`timescale 1ns/10ps

module InstMemory import RvPkg::*; (
    input  logic               Clock,
    input  logic [PcWidth-1:0] instAddr,
    output logic [31:0]        instr
);

    // Program image, one word per line
    logic [31:0] rom [InstMemWords];

    initial begin
        $readmemh("program.hex", rom);
    end

    // Word index, byte offset dropped
    always_ff @(posedge Clock) begin
        instr <= rom[instAddr[InstIndexWidth+1:2]];
    end

endmodule

// File: source/FetchStage.sv
`timescale 1ns/10ps

module FetchStage import RvPkg::*; (
    input  logic               Clock,
    input  logic               rst,
    input  logic               redirect,
    input  logic [PcWidth-1:0] redirectPc,
    output logic [PcWidth-1:0] instAddr,
    output FetchToDecodeT      fetchOut,
    input  logic [31:0]        instr
);

    logic [PcWidth-1:0] pc;
    logic [PcWidth-1:0] fetchPc;
    logic               fetchValid;

    // ------------------------------
    // Program counter
    // ------------------------------
    // Address goes straight to the ROM
    assign instAddr = pc;

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // ------------------------------
    // Fetch register
    // ------------------------------
    // Remember which address the ROM is answering
    always_ff @(posedge Clock) begin
        fetchPc <= pc;
    end

    // Word in flight is stale after a redirect
    always_ff @(posedge Clock) begin
        if (rst) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= !redirect;
        end
    end

    always_comb begin
        fetchOut.valid = fetchValid;
        fetchOut.pc    = fetchPc;
        fetchOut.instr = instr;
    end

endmodule

// File: source/RegisterFile.sv
`timescale 1ns/10ps

module RegisterFile import RvPkg::*; (
    input  logic                    Clock,
    input  logic                    rst,
    input  logic [RegAddrWidth-1:0] readAddrA,
    input  logic [RegAddrWidth-1:0] readAddrB,
    output logic [DataWidth-1:0]    readDataA,
    output logic [DataWidth-1:0]    readDataB,
    input  WritebackT               writeback
);

    logic [DataWidth-1:0] regs [RegCount];

    // Asynchronous read ports
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // Single write port, x0 stays zero
    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeback.en && writeback.rd != '0) begin
            regs[writeback.rd] <= writeback.data;
        end
    end

endmodule

// File: source/DecodeStage.sv
`timescale 1ns/10ps

module DecodeStage import RvPkg::*; (
    input  logic                    Clock,
    input  logic                    rst,
    input  FetchToDecodeT           fetchIn,
    input  logic                    redirect,
    output logic [RegAddrWidth-1:0] readAddrA,
    output logic [RegAddrWidth-1:0] readAddrB,
    input  logic [DataWidth-1:0]    readDataA,
    input  logic [DataWidth-1:0]    readDataB,
    input  WritebackT               writeback,
    output DecodeToExecT            decodeOut
);

    logic [31:0]             instr;
    OpcodeE                  opcode;
    logic [2:0]              funct3;
    AluOpE                   functAlu;
    logic [DataWidth-1:0]    immI, immS, immB, immU, immJ;
    logic [DataWidth-1:0]    imm;
    logic                    useImm;
    logic                    forwardA, forwardB;
    logic [DataWidth-1:0]    srcA, srcB;
    DecodeToExecT            decodeNext;

    // ------------------------------
    // Field split
    // ------------------------------
    assign instr     = fetchIn.instr;
    assign opcode    = OpcodeE'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign readAddrA = instr[19:15];
    assign readAddrB = instr[24:20];

    // Immediates, all sign-extended except U
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // ------------------------------
    // Forwarding from execute
    // ------------------------------
    assign forwardA = writeback.en && writeback.rd != '0 && writeback.rd == readAddrA;
    assign forwardB = writeback.en && writeback.rd != '0 && writeback.rd == readAddrB;
    assign srcA     = forwardA ? writeback.data : readDataA;
    assign srcB     = forwardB ? writeback.data : readDataB;

    // funct3 to ALU op, bit 30 picks SUB for register ops only
    always_comb begin
        case (funct3)
            3'b111:  functAlu = AluAnd;
            3'b110:  functAlu = AluOr;
            3'b100:  functAlu = AluXor;
            default: functAlu = (opcode == OpReg && instr[30]) ? AluSub : AluAdd;
        endcase
    end

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        decodeNext                = '0;
        decodeNext.valid          = fetchIn.valid;
        decodeNext.pc             = fetchIn.pc;
        decodeNext.aluOp          = AluAdd;
        decodeNext.rd             = instr[11:7];
        decodeNext.branchNotEqual = funct3[0];
        decodeNext.branchOffset   = (opcode == OpJal) ? immJ : immB;
        useImm                    = 1'b0;
        imm                       = immI;
        case (opcode)
            OpReg: begin
                decodeNext.regWrite = 1'b1;
                decodeNext.aluOp    = functAlu;
            end
            OpImm: begin
                decodeNext.regWrite = 1'b1;
                decodeNext.aluOp    = functAlu;
                useImm              = 1'b1;
            end
            OpLui: begin
                decodeNext.regWrite = 1'b1;
                decodeNext.aluOp    = AluPassB;
                useImm              = 1'b1;
                imm                 = immU;
            end
            // Address is rs1 plus offset
            OpLoad: begin
                decodeNext.regWrite = 1'b1;
                decodeNext.isLoad   = 1'b1;
                useImm              = 1'b1;
            end
            OpStore: begin
                decodeNext.isStore = 1'b1;
                useImm             = 1'b1;
                imm                = immS;
            end
            // Compare rs1 against rs2
            OpBranch: decodeNext.isBranch = 1'b1;
            // Link register gets pc plus 4 in execute
            OpJal: begin
                decodeNext.regWrite = 1'b1;
                decodeNext.isJump   = 1'b1;
            end
            // Anything else runs as a bubble
            default: decodeNext.valid = 1'b0;
        endcase
        decodeNext.operandA  = srcA;
        decodeNext.operandB  = useImm ? imm : srcB;
        decodeNext.storeData = srcB;
    end

    // ------------------------------
    // Decode-to-execute register
    // ------------------------------
    always_ff @(posedge Clock) begin
        decodeOut <= decodeNext;
        // Squash on reset or a taken branch in execute
        if (rst || redirect) begin
            decodeOut.valid <= 1'b0;
        end
    end

endmodule

// File: source/ExecuteStage.sv
`timescale 1ns/10ps

module ExecuteStage import RvPkg::*; (
    input  DecodeToExecT         decodeIn,
    output DataBusT              dataBus,
    input  logic [DataWidth-1:0] rdData,
    output WritebackT            writeback,
    output logic                 redirect,
    output logic [PcWidth-1:0]   redirectPc
);

    logic [DataWidth-1:0] aluResult;
    logic                 operandsEqual;
    logic                 branchTaken;
    logic [PcWidth-1:0]   linkAddr;

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (decodeIn.aluOp)
            AluAdd:   aluResult = decodeIn.operandA + decodeIn.operandB;
            AluSub:   aluResult = decodeIn.operandA - decodeIn.operandB;
            AluAnd:   aluResult = decodeIn.operandA & decodeIn.operandB;
            AluOr:    aluResult = decodeIn.operandA | decodeIn.operandB;
            AluXor:   aluResult = decodeIn.operandA ^ decodeIn.operandB;
            AluPassB: aluResult = decodeIn.operandB;
            default:  aluResult = '0;
        endcase
    end

    // ------------------------------
    // Branch and jump
    // ------------------------------
    // For branches operandB carries rs2
    assign operandsEqual = decodeIn.operandA == decodeIn.operandB;
    assign branchTaken   = decodeIn.isBranch && (operandsEqual != decodeIn.branchNotEqual);

    // Only a live instruction may steer fetch
    assign redirect   = decodeIn.valid && (branchTaken || decodeIn.isJump);
    assign redirectPc = decodeIn.pc + decodeIn.branchOffset;
    assign linkAddr   = decodeIn.pc + 32'd4;

    // ------------------------------
    // Data bus request
    // ------------------------------
    always_comb begin
        dataBus.addr   = aluResult;
        dataBus.wrData = decodeIn.storeData;
        dataBus.wrEn   = decodeIn.valid && decodeIn.isStore;
        dataBus.rdEn   = decodeIn.valid && decodeIn.isLoad;
    end

    // ------------------------------
    // Writeback
    // ------------------------------
    // Load data comes back in this same cycle
    always_comb begin
        writeback.en = decodeIn.valid && decodeIn.regWrite;
        writeback.rd = decodeIn.rd;
        if (decodeIn.isJump) begin
            writeback.data = linkAddr;
        end else if (decodeIn.isLoad) begin
            writeback.data = rdData;
        end else begin
            writeback.data = aluResult;
        end
    end

endmodule

// File: source/DataMemory.sv
`timescale 1ns/10ps

module DataMemory import RvPkg::*; (
    input  logic                 Clock,
    input  logic                 rst,
    input  DataBusT              dataBus,
    output logic [DataWidth-1:0] rdData,
    input  logic [3:0]           switches,
    output logic [7:0]           leds
);

    logic [DataWidth-1:0]      ram [DataMemWords];
    logic [DataIndexWidth-1:0] wordIndex;
    logic                      selLed;
    logic                      selSwitch;
    logic                      selRam;

    // ------------------------------
    // Address decode
    // ------------------------------
    // I/O addresses shadow the RAM words they overlap
    assign selLed    = dataBus.addr == LedAddr;
    assign selSwitch = dataBus.addr == SwitchAddr;
    assign selRam    = !selLed && !selSwitch;
    assign wordIndex = dataBus.addr[DataIndexWidth+1:2];

    // RAM write
    always_ff @(posedge Clock) begin
        if (dataBus.wrEn && selRam) begin
            ram[wordIndex] <= dataBus.wrData;
        end
    end

    // LED port keeps the low byte
    always_ff @(posedge Clock) begin
        if (rst) begin
            leds <= '0;
        end else if (dataBus.wrEn && selLed) begin
            leds <= dataBus.wrData[7:0];
        end
    end

    // ------------------------------
    // Read path
    // ------------------------------
    always_comb begin
        if (selSwitch) begin
            rdData = {{(DataWidth-4){1'b0}}, switches};
        end else begin
            rdData = ram[wordIndex];
        end
    end

endmodule

// File: source/RvTop.sv
`timescale 1ns/10ps

module RvTop import RvPkg::*; (
    input  logic       Clock,
    input  logic       rst,
    input  logic [3:0] switches,
    output logic [7:0] leds
);

    // Fetch side
    logic [PcWidth-1:0]      instAddr;
    logic [31:0]             instr;
    FetchToDecodeT           fetchToDecode;

    // Register file ports
    logic [RegAddrWidth-1:0] readAddrA;
    logic [RegAddrWidth-1:0] readAddrB;
    logic [DataWidth-1:0]    readDataA;
    logic [DataWidth-1:0]    readDataB;

    // Execute side
    DecodeToExecT            decodeToExec;
    WritebackT               writeback;
    DataBusT                 dataBus;
    logic [DataWidth-1:0]    rdData;
    logic                    redirect;
    logic [PcWidth-1:0]      redirectPc;

    // ------------------------------
    // Fetch
    // ------------------------------
    FetchStage fetch (
        .Clock      (Clock),
        .rst        (rst),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instAddr   (instAddr),
        .fetchOut   (fetchToDecode),
        .instr      (instr)
    );

    InstMemory instMem (
        .Clock    (Clock),
        .instAddr (instAddr),
        .instr    (instr)
    );

    // ------------------------------
    // Decode
    // ------------------------------
    DecodeStage decode (
        .Clock     (Clock),
        .rst       (rst),
        .fetchIn   (fetchToDecode),
        .redirect  (redirect),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeback (writeback),
        .decodeOut (decodeToExec)
    );

    RegisterFile regFile (
        .Clock     (Clock),
        .rst       (rst),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeback (writeback)
    );

    // ------------------------------
    // Execute and data side
    // ------------------------------
    ExecuteStage execute (
        .decodeIn   (decodeToExec),
        .dataBus    (dataBus),
        .rdData     (rdData),
        .writeback  (writeback),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    // RAM plus LED and switch ports
    DataMemory dataMem (
        .Clock    (Clock),
        .rst      (rst),
        .dataBus  (dataBus),
        .rdData   (rdData),
        .switches (switches),
        .leds     (leds)
    );

endmodule

// File: verif/RvTop_assertions.sv
`timescale 1ns/10ps

module RvTopAssertions import RvPkg::*; (
    input logic          Clock,
    input logic          rst,
    input DataBusT       dataBus,
    input logic          redirect,
    input FetchToDecodeT fetchToDecode
);

    // ------------------------------
    // Data bus
    // ------------------------------
    // One instruction either loads or stores
    noReadWriteOverlap: assert property (@(posedge Clock) disable iff (rst)
        !(dataBus.wrEn && dataBus.rdEn))
        else $error("data bus read and write enabled together");

    // Word stores only
    alignedStore: assert property (@(posedge Clock) disable iff (rst)
        dataBus.wrEn |-> dataBus.addr[1:0] == 2'b00)
        else $error("store to unaligned address %h", dataBus.addr);

    // ------------------------------
    // Redirect
    // ------------------------------
    // Word fetched during the redirect cycle is dropped
    flushAfterRedirect: assert property (@(posedge Clock) disable iff (rst)
        redirect |=> !fetchToDecode.valid)
        else $error("fetch still valid in the cycle after a redirect");

endmodule

bind RvTop RvTopAssertions u_assertions (
    .Clock         (Clock),
    .rst           (rst),
    .dataBus       (dataBus),
    .redirect      (redirect),
    .fetchToDecode (fetchToDecode)
);

// File: verif/RvTopTb.sv
`timescale 1ns/10ps

module RvTopTb;

    // One table row holds a switch setting and the LED value it must produce
    typedef struct packed {
        logic [3:0] switchValue;
        logic [7:0] ledValue;
    } TableEntryT;

    logic        Clock;
    logic        rst;
    logic [3:0]  switches;
    logic [7:0]  leds;

    TableEntryT  stimTable [$];
    int unsigned lcgState;

    RvTop u_dut (
        .Clock    (Clock),
        .rst      (rst),
        .switches (switches),
        .leds     (leds)
    );

    // ------------------------------
    // Clock with a 4 ns period
    // ------------------------------
    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    // Sum of 1 to S plus 3S plus 5 XORed with 0x5A in the low byte
    function automatic logic [7:0] expectedLeds(input logic [3:0] s);
        int total;
        total = 3 * int'(s) + 5;
        for (int i = 1; i <= int'(s); i++) begin
            total += i;
        end
        return 8'(total) ^ 8'h5A;
    endfunction

    // Plain 32-bit LCG step
    function automatic int unsigned lcgNext(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // ------------------------------
    // Checking helpers
    // ------------------------------
    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string testName, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("MISMATCH %s expected 0x%02h actual 0x%02h",
                                      testName, expected, actual));
        end
    endtask

    // Poll on falling edges where leds is stable
    task automatic waitForLeds(input string testName, input logic [7:0] expected);
        int cycles;
        cycles = 0;
        do begin
            @(negedge Clock);
            cycles++;
        end while (leds !== expected && cycles < 2000);
        if (leds !== expected) begin
            stopWithFailure($sformatf("Timeout in %s: leds still 0x%02h after %0d cycles",
                                      testName, leds, cycles));
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        TableEntryT entry;
        string      testName;

        rst      = 1'b1;
        switches = 4'd0;
        lcgState = 32'd60364;

        // All sixteen settings first
        // Zero skips the loop and fifteen runs it longest
        for (int s = 0; s < 16; s++) begin
            entry.switchValue = 4'(s);
            entry.ledValue    = expectedLeds(4'(s));
            stimTable.push_back(entry);
        end
        // Then a few pseudo-random settings
        for (int n = 0; n < 6; n++) begin
            lcgState          = lcgNext(lcgState);
            entry.switchValue = lcgState[19:16];
            entry.ledValue    = expectedLeds(lcgState[19:16]);
            stimTable.push_back(entry);
        end

        // Reset held for 8 cycles
        repeat (8) @(posedge Clock);
        rst <= 1'b0;

        // LED register must come out of reset cleared
        @(negedge Clock);
        checkValue("leds after reset", 8'h00, leds);

        foreach (stimTable[i]) begin
            testName = $sformatf("entry %0d switches %0d", i, stimTable[i].switchValue);
            @(posedge Clock);
            switches <= stimTable[i].switchValue;
            waitForLeds(testName, stimTable[i].ledValue);
        end

        // Reset again while the LEDs are lit
        @(posedge Clock);
        rst <= 1'b1;
        repeat (8) @(posedge Clock);
        rst <= 1'b0;
        @(negedge Clock);
        checkValue("leds after second reset", 8'h00, leds);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: program.hex
// Switch to LED program, one 32-bit instruction word per line
// Words start at byte address 0x000; trailing comment gives address and assembly
000000B7 // 00 lui  x1, 0x0          I/O base, upper part
2000E093 // 04 ori  x1, x1, 0x200    I/O base, LED register
0040A103 // 08 lw   x2, 4(x1)        S from the switch port
0001F1B3 // 0C and  x3, x3, x0       sum = 0
00016233 // 10 or   x4, x2, x0       counter = S
00020863 // 14 beq  x4, x0, 0x24     skip loop when S is zero
004181B3 // 18 add  x3, x3, x4       sum += counter
FFF20213 // 1C addi x4, x4, -1
FE021CE3 // 20 bne  x4, x0, 0x18     countdown loop
002102B3 // 24 add  x5, x2, x2       2S
002282B3 // 28 add  x5, x5, x2       3S
005181B3 // 2C add  x3, x3, x5
00518193 // 30 addi x3, x3, 5
04302023 // 34 sw   x3, 0x40(x0)     park in RAM word 0x10
403181B3 // 38 sub  x3, x3, x3       wipe the register copy
04002303 // 3C lw   x6, 0x40(x0)     reload from RAM
05A34313 // 40 xori x6, x6, 0x5A
0FF37313 // 44 andi x6, x6, 0xFF
0060A023 // 48 sw   x6, 0(x1)        drive the LEDs
FBDFF3EF // 4C jal  x7, 0x08         back to the switch read
00000000 // 50 filler, flushed by the jump
00000000 // 54 filler, flushed by the jump
00000000 // 58 filler
00000000 // 5C filler

// File: filelist.f
source/RvPkg.sv
source/InstMemory.sv
source/FetchStage.sv
source/RegisterFile.sv
source/DecodeStage.sv
source/ExecuteStage.sv
source/DataMemory.sv
source/RvTop.sv
verif/RvTop_assertions.sv
verif/RvTopTb.sv

// File: Makefile
SOURCES := $(shell grep -v '^+' filelist.f)

all: obj_dir/VRvTopTb

obj_dir/VRvTopTb: $(SOURCES) filelist.f
	verilator --binary --assert --top-module RvTopTb -f filelist.f

run: obj_dir/VRvTopTb
	./obj_dir/VRvTopTb

clean:
	rm -rf obj_dir

.PHONY: all run clean
